// ==== design/fe_be_pkg.sv ====
// Shared widths, opcode and exception cause codes for the core
// Front-end queue entry with its fetch and exception views

package fe_be_pkg;

    localparam int pc_width_lp    = 12;
    localparam int instr_width_lp = 16;
    localparam int cause_width_lp = 4;

    // Top nibble of a jump; the low 12 bits hold the target word address
    localparam logic [3:0] op_jump_lp = 4'hF;

    localparam logic [cause_width_lp-1:0] e_cause_fetch_fault = 4'd1;

    // Fetched instruction
    typedef struct packed {
        logic                      epoch;
        logic                      exc;
        logic [pc_width_lp-1:0]    pc;
        logic [instr_width_lp-1:0] instr;
    } fe_fetch_s;

    // Exception raised by the front end
    typedef struct packed {
        logic                                     epoch;
        logic                                     exc;
        logic [pc_width_lp-1:0]                   pc;
        logic [cause_width_lp-1:0]                cause;
        logic [instr_width_lp-cause_width_lp-1:0] pad;
    } fe_exc_s;

    // Epoch and kind bits line up in both views, so either one tells them apart
    typedef union packed {
        fe_fetch_s fetch;
        fe_exc_s   exception;
    } fe_entry_u;

    localparam int fe_entry_width_lp = $bits(fe_entry_u);

endpackage

// ==== design/fe_fetch.sv ====
// Front end: PC, instruction port requests and queue push
// Redirects from the back end move the PC and flip the epoch

`timescale 1ns/1ns

module fe_fetch
    import fe_be_pkg::*;
(
    input                               clk_i,
    input                               reset_i,
    input        [pc_width_lp-1:0]      pc_entry_point_i,

    output                              imem_v_o,
    output       [pc_width_lp-1:0]      imem_addr_o,
    input                               imem_ready_i,
    input                               imem_data_v_i,
    input        [instr_width_lp-1:0]   imem_data_i,
    input                               imem_err_i,

    output fe_entry_u                   fe_queue_o,
    output                              fe_queue_v_o,
    input                               fe_queue_ready_i,

    input        [pc_width_lp-1:0]      fe_cmd_i,
    input                               fe_cmd_v_i,
    output                              fe_cmd_yumi_o
);

    logic                   run_r;
    logic [pc_width_lp-1:0] pc_r;
    logic [pc_width_lp-1:0] req_pc_r;
    logic                   pend_r;
    logic                   drop_r;
    logic                   epoch_r;
    logic                   hold_v_r;
    fe_entry_u              hold_r;
    fe_entry_u              resp_entry;
    logic                   req_fire;
    logic                   resp_live;

    // A command is taken the cycle it shows up
    assign fe_cmd_yumi_o = fe_cmd_v_i;

    // One request in flight, and none while an entry waits for the queue
    assign imem_v_o    = run_r & ~pend_r & ~hold_v_r & ~fe_cmd_v_i;
    assign imem_addr_o = pc_r;
    assign req_fire    = imem_v_o & imem_ready_i;

    assign resp_live = imem_data_v_i & ~drop_r & ~fe_cmd_v_i;

    always_comb begin
        resp_entry = '0;
        if (imem_err_i) begin
            resp_entry.exception.epoch = epoch_r;
            resp_entry.exception.exc   = 1'b1;
            resp_entry.exception.pc    = req_pc_r;
            resp_entry.exception.cause = e_cause_fetch_fault;
        end else begin
            resp_entry.fetch.epoch = epoch_r;
            resp_entry.fetch.exc   = 1'b0;
            resp_entry.fetch.pc    = req_pc_r;
            resp_entry.fetch.instr = imem_data_i;
        end
    end

    assign fe_queue_o   = hold_v_r ? hold_r : resp_entry;
    assign fe_queue_v_o = fe_queue_ready_i & (hold_v_r | resp_live);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            run_r    <= 1'b0;
            pc_r     <= pc_entry_point_i;
            pend_r   <= 1'b0;
            drop_r   <= 1'b0;
            epoch_r  <= 1'b0;
            hold_v_r <= 1'b0;
        end else begin
            run_r <= 1'b1;
            if (fe_cmd_v_i) begin
                pc_r    <= fe_cmd_i;
                epoch_r <= ~epoch_r;
            end else if (req_fire) begin
                pc_r <= pc_r + 1'b1;
            end
            if (req_fire) begin
                pend_r <= 1'b1;
            end else if (imem_data_v_i) begin
                pend_r <= 1'b0;
            end
            // Response still owed by the old path gets thrown away
            if (imem_data_v_i) begin
                drop_r <= 1'b0;
            end else if (fe_cmd_v_i && pend_r) begin
                drop_r <= 1'b1;
            end
            if (fe_cmd_v_i) begin
                hold_v_r <= 1'b0;
            end else if (resp_live && !fe_queue_ready_i) begin
                hold_v_r <= 1'b1;
            end else if (fe_queue_ready_i) begin
                hold_v_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_pc_r <= pc_r;
        end
        if (resp_live && !fe_queue_ready_i) begin
            hold_r <= resp_entry;
        end
    end

    // After an accepted request the port stays quiet until the answer comes back
    a_one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
        (imem_v_o && imem_ready_i) |=> (!imem_v_o until_with imem_data_v_i));

endmodule

// ==== design/fe_queue_rolly.sv ====
// Front-end queue with speculative read, checkpoint and rollback
// Depth must be a power of two

`timescale 1ns/1ns

module fe_queue_rolly
    import fe_be_pkg::*;
#(
    parameter int els_p = 8
)
(
    input             clk_i,
    input             reset_i,

    input             clr_v_i,
    input             ckpt_v_i,
    input             roll_v_i,

    input  fe_entry_u data_i,
    input             v_i,
    output            ready_o,

    output fe_entry_u data_o,
    output            v_o,
    input             yumi_i
);

    localparam int idx_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

    fe_entry_u         mem_r [els_p];
    logic [idx_w_lp:0] wptr_r;
    logic [idx_w_lp:0] rptr_r;
    logic [idx_w_lp:0] cptr_r;
    logic [idx_w_lp:0] cptr_n;
    logic              full;
    logic              empty;

    // Reads run ahead of the checkpoint; space frees only as entries retire
    assign empty = (rptr_r == wptr_r);
    assign full  = (cptr_r[idx_w_lp-1:0] == wptr_r[idx_w_lp-1:0])
                && (cptr_r[idx_w_lp] != wptr_r[idx_w_lp]);

    assign ready_o = ~full;
    assign v_o     = ~empty;
    assign data_o  = mem_r[rptr_r[idx_w_lp-1:0]];

    always_comb begin
        if (clr_v_i) begin
            cptr_n = wptr_r;
        end else if (ckpt_v_i) begin
            cptr_n = cptr_r + 1'b1;
        end else begin
            cptr_n = cptr_r;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wptr_r <= '0;
            rptr_r <= '0;
            cptr_r <= '0;
        end else begin
            if (v_i) begin
                wptr_r <= wptr_r + 1'b1;
            end
            cptr_r <= cptr_n;
            // Clear skips everything already written; a same-cycle push survives
            if (clr_v_i) begin
                rptr_r <= wptr_r;
            end else if (roll_v_i) begin
                rptr_r <= cptr_n;
            end else if (yumi_i) begin
                rptr_r <= rptr_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (v_i) begin
            mem_r[wptr_r[idx_w_lp-1:0]] <= data_i;
        end
    end

    a_push_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        v_i |-> ready_o);

    a_yumi_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        yumi_i |-> v_o);

    // Clear and rollback never arrive together
    a_clr_roll_apart: assert property (@(posedge clk_i) disable iff (reset_i)
        !(clr_v_i && roll_v_i));

    // Checkpoint only moves over entries the back end has already read
    a_ckpt_behind_read: assert property (@(posedge clk_i) disable iff (reset_i)
        (ckpt_v_i && !clr_v_i) |-> (cptr_r != rptr_r));

endmodule

// ==== design/fe_cmd_fifo.sv ====
// Redirect command FIFO from the back end to the front end

`timescale 1ns/1ns

module fe_cmd_fifo
    import fe_be_pkg::*;
#(
    parameter int els_p = 2
)
(
    input                    clk_i,
    input                    reset_i,

    input  [pc_width_lp-1:0] data_i,
    input                    v_i,
    output                   ready_o,

    output [pc_width_lp-1:0] data_o,
    output                   v_o,
    input                    yumi_i
);

    localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

    logic [pc_width_lp-1:0] mem_r [els_p];
    logic [ptr_w_lp-1:0]    wptr_r;
    logic [ptr_w_lp-1:0]    rptr_r;
    logic [ptr_w_lp-1:0]    wptr_next;
    logic [ptr_w_lp-1:0]    rptr_next;
    logic                   full_r;
    logic                   empty_r;

    assign wptr_next = (wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
    assign rptr_next = (rptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;

    assign ready_o = ~full_r;
    assign v_o     = ~empty_r;
    assign data_o  = mem_r[rptr_r];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wptr_r  <= '0;
            rptr_r  <= '0;
            full_r  <= 1'b0;
            empty_r <= 1'b1;
        end else begin
            if (v_i) begin
                wptr_r <= wptr_next;
            end
            if (yumi_i) begin
                rptr_r <= rptr_next;
            end
            // Occupancy only changes when one side moves alone
            if (v_i != yumi_i) begin
                full_r  <= v_i & (wptr_next == rptr_r);
                empty_r <= yumi_i & (rptr_next == wptr_r);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (v_i) begin
            mem_r[wptr_r] <= data_i;
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        v_i |-> !full_r);

endmodule

// ==== design/be_exec.sv ====
// Back end: issue from the front-end queue, epoch filter, redirects
// Freeze rollback and the commit stage

`timescale 1ns/1ns

module be_exec
    import fe_be_pkg::*;
#(
    parameter logic [pc_width_lp-1:0] trap_vec_p = 12'h080
)
(
    input                             clk_i,
    input                             reset_i,
    input                             freeze_i,

    input  fe_entry_u                 fe_queue_i,
    input                             fe_queue_v_i,
    output                            fe_queue_yumi_o,

    output                            fe_queue_clr_o,
    output                            fe_queue_ckpt_o,
    output                            fe_queue_roll_o,

    output       [pc_width_lp-1:0]    fe_cmd_o,
    output                            fe_cmd_v_o,
    input                             fe_cmd_ready_i,

    output                            commit_v_o,
    output       [pc_width_lp-1:0]    commit_pc_o,
    output       [instr_width_lp-1:0] commit_instr_o,
    output                            commit_exc_o
);

    logic                      epoch_r;
    logic                      freeze_r;
    logic                      ckpt_pend_r;
    logic                      cmt_v_r;
    logic                      cmt_exc_r;
    logic                      cmt_redir_r;
    logic [pc_width_lp-1:0]    cmt_pc_r;
    logic [instr_width_lp-1:0] cmt_instr_r;
    logic                      entry_exc;
    logic                      entry_stale;
    logic                      entry_jump;
    logic                      entry_redir;
    logic [instr_width_lp-1:0] entry_instr;
    logic                      issue;

    assign entry_exc   = fe_queue_i.fetch.exc;
    assign entry_stale = (fe_queue_i.fetch.epoch != epoch_r);
    assign entry_jump  = ~entry_exc
                       & (fe_queue_i.fetch.instr[instr_width_lp-1 -: 4] == op_jump_lp);
    assign entry_redir = ~entry_stale & (entry_exc | entry_jump);

    // Exceptions retire with their cause in place of an instruction
    assign entry_instr = entry_exc
        ? {{(instr_width_lp-cause_width_lp){1'b0}}, fe_queue_i.exception.cause}
        : fe_queue_i.fetch.instr;

    // A redirect waits for room in the command FIFO
    assign issue = fe_queue_v_i & ~freeze_i & (~entry_redir | fe_cmd_ready_i);

    assign fe_queue_yumi_o = issue;
    assign fe_cmd_v_o      = issue & entry_redir;
    assign fe_cmd_o        = entry_exc ? trap_vec_p : fe_queue_i.fetch.instr[pc_width_lp-1:0];
    assign fe_queue_clr_o  = fe_cmd_v_o;

    // Clear already steps past a redirect, so only the others checkpoint
    assign fe_queue_ckpt_o = ckpt_pend_r & ~freeze_i;
    assign fe_queue_roll_o = freeze_i & ~freeze_r;

    assign commit_v_o     = cmt_v_r & ~freeze_i;
    assign commit_pc_o    = cmt_pc_r;
    assign commit_instr_o = cmt_instr_r;
    assign commit_exc_o   = cmt_exc_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            epoch_r     <= 1'b0;
            freeze_r    <= 1'b0;
            ckpt_pend_r <= 1'b0;
            cmt_v_r     <= 1'b0;
        end else begin
            freeze_r    <= freeze_i;
            ckpt_pend_r <= issue & ~entry_redir;
            if (fe_cmd_v_o) begin
                epoch_r <= ~epoch_r;
            end
            // Frozen entries replay from the queue, except a redirect already sent
            if (freeze_i) begin
                cmt_v_r <= cmt_v_r & cmt_redir_r;
            end else begin
                cmt_v_r <= issue & ~entry_stale;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            cmt_pc_r    <= fe_queue_i.fetch.pc;
            cmt_instr_r <= entry_instr;
            cmt_exc_r   <= entry_exc;
            cmt_redir_r <= entry_redir;
        end
    end

    // Past the first frozen cycle only a redirect already sent waits to commit
    a_no_commit_frozen: assert property (@(posedge clk_i) disable iff (reset_i)
        (freeze_i && freeze_r && cmt_v_r) |-> cmt_redir_r);

endmodule

// ==== design/fe_be_core.sv ====
// Core top level: front end, front-end queue, command FIFO and back end

`timescale 1ns/1ns

module fe_be_core
    import fe_be_pkg::*;
#(
    parameter int                     queue_els_p = 8,
    parameter int                     cmd_els_p   = 2,
    parameter logic [pc_width_lp-1:0] trap_vec_p  = 12'h080
)
(
    input                       clk_i,
    input                       reset_i,
    input                       freeze_i,
    input  [pc_width_lp-1:0]    pc_entry_point_i,

    output                      imem_v_o,
    output [pc_width_lp-1:0]    imem_addr_o,
    input                       imem_ready_i,
    input                       imem_data_v_i,
    input  [instr_width_lp-1:0] imem_data_i,
    input                       imem_err_i,

    output                      commit_v_o,
    output [pc_width_lp-1:0]    commit_pc_o,
    output [instr_width_lp-1:0] commit_instr_o,
    output                      commit_exc_o
);

    fe_entry_u              fe_queue_li;
    fe_entry_u              fe_queue_lo;
    logic                   fe_queue_v_li;
    logic                   fe_queue_ready_lo;
    logic                   fe_queue_v_lo;
    logic                   fe_queue_yumi_li;
    logic                   fe_queue_clr_li;
    logic                   fe_queue_ckpt_li;
    logic                   fe_queue_roll_li;

    logic [pc_width_lp-1:0] fe_cmd_li;
    logic [pc_width_lp-1:0] fe_cmd_lo;
    logic                   fe_cmd_v_li;
    logic                   fe_cmd_ready_lo;
    logic                   fe_cmd_v_lo;
    logic                   fe_cmd_yumi_li;

    fe_fetch fe (
        .clk_i(clk_i), .reset_i(reset_i), .pc_entry_point_i(pc_entry_point_i),
        .imem_v_o(imem_v_o), .imem_addr_o(imem_addr_o), .imem_ready_i(imem_ready_i),
        .imem_data_v_i(imem_data_v_i), .imem_data_i(imem_data_i), .imem_err_i(imem_err_i),
        .fe_queue_o(fe_queue_li), .fe_queue_v_o(fe_queue_v_li),
        .fe_queue_ready_i(fe_queue_ready_lo),
        .fe_cmd_i(fe_cmd_lo), .fe_cmd_v_i(fe_cmd_v_lo), .fe_cmd_yumi_o(fe_cmd_yumi_li)
    );

    fe_queue_rolly #(.els_p(queue_els_p)) queue_fifo (
        .clk_i(clk_i), .reset_i(reset_i),
        .clr_v_i(fe_queue_clr_li), .ckpt_v_i(fe_queue_ckpt_li), .roll_v_i(fe_queue_roll_li),
        .data_i(fe_queue_li), .v_i(fe_queue_v_li), .ready_o(fe_queue_ready_lo),
        .data_o(fe_queue_lo), .v_o(fe_queue_v_lo), .yumi_i(fe_queue_yumi_li)
    );

    fe_cmd_fifo #(.els_p(cmd_els_p)) cmd_fifo (
        .clk_i(clk_i), .reset_i(reset_i),
        .data_i(fe_cmd_li), .v_i(fe_cmd_v_li), .ready_o(fe_cmd_ready_lo),
        .data_o(fe_cmd_lo), .v_o(fe_cmd_v_lo), .yumi_i(fe_cmd_yumi_li)
    );

    be_exec #(.trap_vec_p(trap_vec_p)) be (
        .clk_i(clk_i), .reset_i(reset_i), .freeze_i(freeze_i),
        .fe_queue_i(fe_queue_lo), .fe_queue_v_i(fe_queue_v_lo),
        .fe_queue_yumi_o(fe_queue_yumi_li),
        .fe_queue_clr_o(fe_queue_clr_li), .fe_queue_ckpt_o(fe_queue_ckpt_li),
        .fe_queue_roll_o(fe_queue_roll_li),
        .fe_cmd_o(fe_cmd_li), .fe_cmd_v_o(fe_cmd_v_li), .fe_cmd_ready_i(fe_cmd_ready_lo),
        .commit_v_o(commit_v_o), .commit_pc_o(commit_pc_o),
        .commit_instr_o(commit_instr_o), .commit_exc_o(commit_exc_o)
    );

endmodule

// ==== bench/imem_model.sv ====
// Instruction memory model for the core testbench
// Random request ready, in-order response one cycle after acceptance

`timescale 1ns/1ns

module imem_model
    import fe_be_pkg::*;
(
    input                             clk_i,
    input                             reset_i,
    input                             v_i,
    input        [pc_width_lp-1:0]    addr_i,
    output logic                      ready_o,
    output logic                      data_v_o,
    output logic [instr_width_lp-1:0] data_o,
    output logic                      err_o
);

    integer                 seed;
    logic                   taken_r;
    logic [pc_width_lp-1:0] taken_addr_r;

    // Every 64th word from offset 37 answers with a bus error
    function automatic logic fault_at(input logic [pc_width_lp-1:0] addr);
        return (addr % 64) == 37;
    endfunction

    function automatic logic [instr_width_lp-1:0] word_at(input logic [pc_width_lp-1:0] addr);
        int target;
        target = (int'(addr) * 5 + 3) % 4096;
        if ((addr % 16) == 15) begin
            return {4'hF, target[11:0]};
        end
        return {4'h0, addr} ^ 16'h5A00;
    endfunction

    initial begin
        seed     = 14122;
        ready_o  = 1'b0;
        data_v_o = 1'b0;
        data_o   = '0;
        err_o    = 1'b0;
        taken_r  = 1'b0;
    end

    always @(posedge clk_i) begin
        taken_r      <= v_i & ready_o & ~reset_i;
        taken_addr_r <= addr_i;
    end

    // Response and next ready change on the falling edge
    always @(negedge clk_i) begin
        data_v_o <= taken_r;
        data_o   <= (taken_r && !fault_at(taken_addr_r)) ? word_at(taken_addr_r) : '0;
        err_o    <= taken_r & fault_at(taken_addr_r);
        ready_o  <= ($random(seed) & 3) != 0;
    end

endmodule

// ==== bench/fe_be_core_tb.sv ====
// Core testbench: clock, reset, freeze stimulus and instruction memory
// Reference PC model checked by assertions on every retirement, timeout

`timescale 1ns/1ns

module fe_be_core_tb
    import fe_be_pkg::*;
();

    localparam logic [pc_width_lp-1:0] entry_pc_lp = 12'h020;
    localparam logic [pc_width_lp-1:0] trap_pc_lp  = 12'h080;
    localparam int retire_goal_lp = 300;
    // Jump pairs cost up to about 12 cycles per retirement under stalls, plus frozen time
    localparam int max_cycles_lp  = retire_goal_lp * 12 + 400;

    logic                      clk;
    logic                      reset;
    logic                      freeze;
    logic [pc_width_lp-1:0]    entry_pc;
    logic                      imem_v;
    logic [pc_width_lp-1:0]    imem_addr;
    logic                      imem_ready;
    logic                      imem_data_v;
    logic [instr_width_lp-1:0] imem_data;
    logic                      imem_err;
    logic                      commit_v;
    logic [pc_width_lp-1:0]    commit_pc;
    logic [instr_width_lp-1:0] commit_instr;
    logic                      commit_exc;

    integer                    seed;
    int                        errors;
    int                        retired;
    int                        cycles;
    logic [pc_width_lp-1:0]    exp_pc;
    logic [instr_width_lp-1:0] exp_word;

    fe_be_core #(.queue_els_p(8), .cmd_els_p(2), .trap_vec_p(trap_pc_lp)) dut_i (
        .clk_i(clk), .reset_i(reset), .freeze_i(freeze), .pc_entry_point_i(entry_pc),
        .imem_v_o(imem_v), .imem_addr_o(imem_addr), .imem_ready_i(imem_ready),
        .imem_data_v_i(imem_data_v), .imem_data_i(imem_data), .imem_err_i(imem_err),
        .commit_v_o(commit_v), .commit_pc_o(commit_pc),
        .commit_instr_o(commit_instr), .commit_exc_o(commit_exc)
    );

    imem_model mem (
        .clk_i(clk), .reset_i(reset), .v_i(imem_v), .addr_i(imem_addr),
        .ready_o(imem_ready), .data_v_o(imem_data_v), .data_o(imem_data), .err_o(imem_err)
    );

    function automatic logic fault_at(input logic [pc_width_lp-1:0] addr);
        return (addr % 64) == 37;
    endfunction

    function automatic logic [instr_width_lp-1:0] word_at(input logic [pc_width_lp-1:0] addr);
        int target;
        target = (int'(addr) * 5 + 3) % 4096;
        if ((addr % 16) == 15) begin
            return {4'hF, target[11:0]};
        end
        return {4'h0, addr} ^ 16'h5A00;
    endfunction

    task automatic finish_run();
        $display("Retired %0d in %0d cycles, %0d errors", retired, cycles, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles_lp) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("Timeout after %0d cycles with only %0d retirements", cycles, retired);
        finish_run();
    end

    // Reference model walks the expected PC sequence from the entry point
    always @(posedge clk) begin
        if (reset) begin
            exp_pc = entry_pc_lp;
        end else begin
            assert (!(freeze && commit_v)) else begin
                errors++;
                $display("Fail commit_v_o: got %h while frozen, expected %h", commit_v, 1'b0);
            end
            if (commit_v) begin
                exp_word = word_at(exp_pc);
                assert (commit_pc == exp_pc) else begin
                    errors++;
                    $display("Fail commit_pc_o: got %h, expected %h", commit_pc, exp_pc);
                end
                assert (commit_exc == fault_at(exp_pc)) else begin
                    errors++;
                    $display("Fail commit_exc_o: got %h, expected %h", commit_exc,
                             fault_at(exp_pc));
                end
                if (!fault_at(exp_pc)) begin
                    assert (commit_instr == exp_word) else begin
                        errors++;
                        $display("Fail commit_instr_o: got %h, expected %h", commit_instr,
                                 exp_word);
                    end
                end
                retired++;
                if (fault_at(exp_pc)) begin
                    exp_pc = trap_pc_lp;
                end else if (exp_word[15:12] == 4'hF) begin
                    exp_pc = exp_word[11:0];
                end else begin
                    exp_pc = exp_pc + 1'b1;
                end
            end
        end
    end

    initial begin
        seed     = 14122;
        errors   = 0;
        retired  = 0;
        reset    = 1'b1;
        freeze   = 1'b0;
        entry_pc = entry_pc_lp;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        // Three freezes of random length at random points in the run
        repeat (3) begin
            repeat (60 + $unsigned($random(seed)) % 120) @(negedge clk);
            freeze = 1'b1;
            repeat (2 + $unsigned($random(seed)) % 15) @(negedge clk);
            freeze = 1'b0;
        end
        wait (retired >= retire_goal_lp);
        @(negedge clk);
        finish_run();
    end

endmodule

// ==== fe_be_core.f ====
design/fe_be_pkg.sv
design/fe_fetch.sv
design/fe_queue_rolly.sv
design/fe_cmd_fifo.sv
design/be_exec.sv
design/fe_be_core.sv
bench/imem_model.sv
bench/fe_be_core_tb.sv
